// File: sources.f
design/fifo_pkg.sv
design/stream_pkg.sv
design/pattern_source.sv
design/pipelined_fifo.sv
design/stream_accumulator.sv
design/stream_top.sv
tb/tb_stream_top.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
verilator --binary --timing --assert -Wno-fatal --top-module tb_stream_top \
    -f sources.f -o sim_stream > build.log 2>&1 &&
./obj_dir/sim_stream > sim.log 2>&1 ||
{ cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "RESULT: PASS" sim.log && echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: tb/tb_stream_top.sv
module tb_stream_top
    import fifo_pkg::*;
    import stream_pkg::*;
();

    logic                   clk;
    logic                   rst_n;
    logic                   start;
    pattern_e               opcode;
    logic [DATA_WIDTH-1:0]  seed;
    logic [LEN_WIDTH-1:0]   length;
    logic                   drain_en;
    logic                   clear;
    logic                   busy;
    logic                   full;
    logic                   almost_full;
    logic                   empty;
    logic                   almost_empty;
    logic [COUNT_WIDTH-1:0] data_count;
    logic                   rd_valid;
    logic [DATA_WIDTH-1:0]  rd_data;
    logic [DATA_WIDTH-1:0]  sum;
    logic [15:0]            word_count;

    // Reference model state
    logic [DATA_WIDTH-1:0]  expected_q [$];
    logic [DATA_WIDTH-1:0]  model_head;
    int                     model_size;
    logic [DATA_WIDTH-1:0]  model_sum;
    logic [15:0]            model_count;

    logic [31:0]            lfsr_state;
    int                     idle_cycles;
    logic                   after_reset;
    logic                   expect_busy;
    logic                   clear_check;
    int                     mismatch_count;
    int                     error_count;

    stream_top i_stream_top (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .opcode       (opcode),
        .seed         (seed),
        .length       (length),
        .drain_en     (drain_en),
        .clear        (clear),
        .busy         (busy),
        .full         (full),
        .almost_full  (almost_full),
        .empty        (empty),
        .almost_empty (almost_empty),
        .data_count   (data_count),
        .rd_valid     (rd_valid),
        .rd_data      (rd_data),
        .sum          (sum),
        .word_count   (word_count)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [31:0] galois_step(input logic [31:0] s);
        return (s >> 1) ^ (s[0] ? 32'hB4BC_D35C : 32'h0);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = galois_step(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    // Word that follows w in the pattern of op
    function automatic logic [DATA_WIDTH-1:0] pattern_next(
        input pattern_e              op,
        input logic [DATA_WIDTH-1:0] w
    );
        if (op == PAT_RAMP) begin
            return w + 32'd1;
        end else if (op == PAT_LFSR) begin
            return w[0] ? ((w >> 1) ^ LFSR_POLY) : (w >> 1);
        end
        return w;
    endfunction

    task automatic report_mismatch(input string msg);
        mismatch_count++;
        $display("MISMATCH at %0t: %s", $time, msg);
    endtask

    // Model consumes one word per rd_valid, same edge as the accumulator
    always @(posedge clk) begin
        logic [DATA_WIDTH-1:0] word;
        word = '0;
        if (rst_n) begin
            if (rd_valid && expected_q.size() > 0) begin
                word = expected_q.pop_front();
            end
            if (clear) begin
                model_sum   <= rd_valid ? word : '0;
                model_count <= rd_valid ? 16'd1 : 16'd0;
            end else if (rd_valid) begin
                model_sum   <= model_sum + word;
                model_count <= model_count + 16'd1;
            end
        end
    end

    // Head of the queue, stable for the next rising edge
    always @(negedge clk) begin
        model_size = expected_q.size();
        model_head = (model_size > 0) ? expected_q[0] : '0;
    end

    // Cycles since the source last wrote, so no write is left in commit
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idle_cycles <= 0;
        end else if (busy) begin
            idle_cycles <= 0;
        end else if (idle_cycles < 15) begin
            idle_cycles <= idle_cycles + 1;
        end
    end

    a_reset_state: assert property (@(posedge clk) after_reset |->
        (!busy && !full && !almost_full && !rd_valid && empty && almost_empty
         && data_count == '0 && sum == '0 && word_count == '0))
        else report_mismatch("outputs after reset differ from reset values");

    a_word_expected: assert property (@(posedge clk) disable iff (!rst_n)
        rd_valid |-> model_size > 0)
        else begin
            error_count++;
            $display("rd_valid at %0t while no word was outstanding", $time);
        end

    a_word_value: assert property (@(posedge clk) disable iff (!rst_n)
        rd_valid && model_size > 0 |-> rd_data == model_head)
        else report_mismatch($sformatf("rd_data %h, expected %h", rd_data, model_head));

    a_count_bound: assert property (@(posedge clk) disable iff (!rst_n)
        data_count <= DEPTH)
        else report_mismatch($sformatf("data_count %0d above depth", data_count));

    // Committed count alone decides empty
    a_empty: assert property (@(posedge clk) disable iff (!rst_n)
        empty == (data_count == '0))
        else report_mismatch($sformatf("empty %b with data_count %0d", empty, data_count));

    a_flags: assert property (@(posedge clk) disable iff (!rst_n)
        idle_cycles > PIPE_STAGES |->
        (almost_full == (data_count >= DEPTH - ALMOST_FULL_MARGIN)
         && almost_empty == (data_count <= ALMOST_EMPTY_MARGIN)
         && full == (data_count == DEPTH)))
        else report_mismatch($sformatf("flags disagree with data_count %0d", data_count));

    a_totals: assert property (@(posedge clk) disable iff (!rst_n)
        sum == model_sum && word_count == model_count)
        else report_mismatch($sformatf("sum %h count %0d, expected %h count %0d",
                                       sum, word_count, model_sum, model_count));

    a_cleared: assert property (@(posedge clk) clear_check |->
        sum == '0 && word_count == '0)
        else report_mismatch("sum or word_count not zero after clear");

    a_busy: assert property (@(posedge clk) expect_busy |-> busy)
        else report_mismatch("source not busy during a command");

    task automatic start_command(input pattern_e op, input logic [DATA_WIDTH-1:0] s,
                                 input logic [LEN_WIDTH-1:0] len);
        logic [DATA_WIDTH-1:0] w;
        w = s;
        @(posedge clk);
        start  <= 1'b1;
        opcode <= op;
        seed   <= s;
        length <= len;
        for (int i = 0; i < int'(len); i++) begin
            expected_q.push_back(w);
            w = pattern_next(op, w);
        end
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic wait_drained(input bit random_drain);
        int          cycles;
        logic [31:0] bit_taken;
        cycles = 0;
        @(negedge clk);
        while ((busy || expected_q.size() != 0) && cycles < 3000) begin
            @(posedge clk);
            if (random_drain) begin
                bit_taken = random_bits(1);
                drain_en <= bit_taken[0];
            end
            @(negedge clk);
            cycles++;
        end
        if (cycles >= 3000) begin
            error_count++;
            $display("Timed out at %0t waiting for the buffer to drain", $time);
        end
        @(posedge clk);
        drain_en <= 1'b1;
    endtask

    task automatic wait_full();
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!full && cycles < 200) begin
            @(negedge clk);
            cycles++;
        end
        if (!full) begin
            error_count++;
            $display("Buffer never reported full by %0t", $time);
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] n;
        rst_n          = 1'b0;
        start          = 1'b0;
        opcode         = PAT_CONST;
        seed           = '0;
        length         = '0;
        drain_en       = 1'b0;
        clear          = 1'b0;
        lfsr_state     = 32'h9f54d0ca;
        model_sum      = '0;
        model_count    = '0;
        after_reset    = 1'b0;
        expect_busy    = 1'b0;
        clear_check    = 1'b0;
        mismatch_count = 0;
        error_count    = 0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        after_reset <= 1'b1;
        @(posedge clk);
        after_reset <= 1'b0;
        drain_en    <= 1'b1;

        // One command per opcode, drained as it goes
        for (int op = 0; op < 3; op++) begin
            r = random_bits(32);
            n = random_bits(5);
            start_command(pattern_e'(op), r, LEN_WIDTH'(n + 1));
            wait_drained(1'b0);
        end

        // Back-pressure, buffer fills with drain off
        @(posedge clk);
        drain_en <= 1'b0;
        r = random_bits(32);
        n = random_bits(3);
        start_command(PAT_LFSR, r, LEN_WIDTH'(n + 24));
        wait_full();
        repeat (6) @(posedge clk);
        drain_en <= 1'b1;
        wait_drained(1'b0);

        // Random drain_en pattern
        r = random_bits(32);
        n = random_bits(4);
        start_command(PAT_RAMP, r, LEN_WIDTH'(n + 40));
        wait_drained(1'b1);

        @(posedge clk);
        clear <= 1'b1;
        @(posedge clk);
        clear <= 1'b0;
        @(posedge clk);
        clear_check <= 1'b1;
        @(posedge clk);
        clear_check <= 1'b0;

        // Second start while busy must be ignored
        r = random_bits(32);
        start_command(PAT_RAMP, r, LEN_WIDTH'(20));
        @(posedge clk);
        start       <= 1'b1;
        opcode      <= PAT_CONST;
        seed        <= 32'h5a5a_5a5a;
        length      <= LEN_WIDTH'(10);
        expect_busy <= 1'b1;
        @(posedge clk);
        start       <= 1'b0;
        expect_busy <= 1'b0;
        wait_drained(1'b0);

        // Zero length command
        start_command(PAT_CONST, 32'h1234_5678, '0);
        wait_drained(1'b0);
        repeat (10) @(posedge clk);

        $display("Checks done: %0d mismatches, %0d other errors", mismatch_count, error_count);
        if (mismatch_count == 0 && error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: design/stream_top.sv
module stream_top
    import fifo_pkg::*;
    import stream_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  pattern_e               opcode,
    input  logic [DATA_WIDTH-1:0]  seed,
    input  logic [LEN_WIDTH-1:0]   length,
    input  logic                   drain_en,
    input  logic                   clear,
    output logic                   busy,
    output logic                   full,
    output logic                   almost_full,
    output logic                   empty,
    output logic                   almost_empty,
    output logic [COUNT_WIDTH-1:0] data_count,
    output logic                   rd_valid,
    output logic [DATA_WIDTH-1:0]  rd_data,
    output logic [DATA_WIDTH-1:0]  sum,
    output logic [15:0]            word_count
);

    logic                  wr_en;
    logic [DATA_WIDTH-1:0] wr_data;
    logic                  rd_en;

    pattern_source i_source (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .opcode  (opcode),
        .seed    (seed),
        .length  (length),
        .full    (full),
        .busy    (busy),
        .wr_en   (wr_en),
        .wr_data (wr_data)
    );

    pipelined_fifo i_fifo (
        .clk          (clk),
        .rst_n        (rst_n),
        .wr_en        (wr_en),
        .wr_data      (wr_data),
        .full         (full),
        .almost_full  (almost_full),
        .rd_en        (rd_en),
        .rd_valid     (rd_valid),
        .rd_data      (rd_data),
        .empty        (empty),
        .almost_empty (almost_empty),
        .data_count   (data_count)
    );

    stream_accumulator i_accumulator (
        .clk        (clk),
        .rst_n      (rst_n),
        .drain_en   (drain_en),
        .clear      (clear),
        .empty      (empty),
        .rd_en      (rd_en),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data),
        .sum        (sum),
        .word_count (word_count)
    );

endmodule

// File: design/stream_accumulator.sv
module stream_accumulator
    import fifo_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  drain_en,
    input  logic                  clear,
    input  logic                  empty,
    output logic                  rd_en,
    input  logic                  rd_valid,
    input  logic [DATA_WIDTH-1:0] rd_data,
    output logic [DATA_WIDTH-1:0] sum,
    output logic [15:0]           word_count
);

    // One read per cycle while there is committed data to take
    assign rd_en = drain_en && !empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum        <= '0;
            word_count <= '0;
        end else if (clear) begin
            // A word arriving with clear starts the new totals
            if (rd_valid) begin
                sum        <= rd_data;
                word_count <= 16'd1;
            end else begin
                sum        <= '0;
                word_count <= '0;
            end
        end else if (rd_valid) begin
            sum        <= sum + rd_data;
            word_count <= word_count + 1'b1;
        end
    end

endmodule

// File: design/pipelined_fifo.sv
module pipelined_fifo
    import fifo_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wr_en,
    input  logic [DATA_WIDTH-1:0]  wr_data,
    output logic                   full,
    output logic                   almost_full,
    input  logic                   rd_en,
    output logic                   rd_valid,
    output logic [DATA_WIDTH-1:0]  rd_data,
    output logic                   empty,
    output logic                   almost_empty,
    output logic [COUNT_WIDTH-1:0] data_count
);

    logic [DATA_WIDTH-1:0]  mem [DEPTH];

    // Issue side, commit side and read pointers
    logic [COUNT_WIDTH-1:0] wr_ptr;
    logic [COUNT_WIDTH-1:0] wr_commit_ptr;
    logic [COUNT_WIDTH-1:0] rd_ptr;
    logic [COUNT_WIDTH-1:0] issued_count;

    // Write commit pipeline, data travels with its address
    logic [PIPE_STAGES-1:0] wr_pipe_en;
    logic [ADDR_WIDTH-1:0]  wr_pipe_addr [PIPE_STAGES];
    logic [DATA_WIDTH-1:0]  wr_pipe_data [PIPE_STAGES];

    // Stage 0 holds the memory word, the rest delay it
    logic [PIPE_STAGES:0]   rd_pipe_valid;
    logic [DATA_WIDTH-1:0]  rd_pipe_data [PIPE_STAGES+1];

    assign issued_count = wr_ptr - rd_ptr;
    assign data_count   = wr_commit_ptr - rd_ptr;

    // full counts writes still in the pipe, so no slot is handed out twice
    assign full         = (issued_count == COUNT_WIDTH'(DEPTH));
    assign almost_full  = (issued_count >= COUNT_WIDTH'(DEPTH - ALMOST_FULL_MARGIN));
    assign empty        = (data_count == '0);
    assign almost_empty = (data_count <= COUNT_WIDTH'(ALMOST_EMPTY_MARGIN));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr        <= '0;
            wr_commit_ptr <= '0;
            wr_pipe_en    <= '0;
        end else begin
            wr_pipe_en[0] <= wr_en;
            for (int i = 1; i < PIPE_STAGES; i++) begin
                wr_pipe_en[i] <= wr_pipe_en[i-1];
            end
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (wr_pipe_en[PIPE_STAGES-1]) begin
                wr_commit_ptr <= wr_commit_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            wr_pipe_addr[0] <= wr_ptr[ADDR_WIDTH-1:0];
            wr_pipe_data[0] <= wr_data;
        end
        for (int i = 1; i < PIPE_STAGES; i++) begin
            wr_pipe_addr[i] <= wr_pipe_addr[i-1];
            wr_pipe_data[i] <= wr_pipe_data[i-1];
        end
    end

    // Commit at the last write stage
    always_ff @(posedge clk) begin
        if (wr_pipe_en[PIPE_STAGES-1]) begin
            mem[wr_pipe_addr[PIPE_STAGES-1]] <= wr_pipe_data[PIPE_STAGES-1];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ptr        <= '0;
            rd_pipe_valid <= '0;
        end else begin
            rd_pipe_valid[0] <= rd_en;
            for (int i = 1; i <= PIPE_STAGES; i++) begin
                rd_pipe_valid[i] <= rd_pipe_valid[i-1];
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Reads only target committed entries since empty follows data_count
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_pipe_data[0] <= mem[rd_ptr[ADDR_WIDTH-1:0]];
        end
        for (int i = 1; i <= PIPE_STAGES; i++) begin
            rd_pipe_data[i] <= rd_pipe_data[i-1];
        end
    end

    assign rd_valid = rd_pipe_valid[PIPE_STAGES];
    assign rd_data  = rd_pipe_data[PIPE_STAGES];

endmodule

// File: design/pattern_source.sv
module pattern_source
    import fifo_pkg::*;
    import stream_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  pattern_e              opcode,
    input  logic [DATA_WIDTH-1:0] seed,
    input  logic [LEN_WIDTH-1:0]  length,
    input  logic                  full,
    output logic                  busy,
    output logic                  wr_en,
    output logic [DATA_WIDTH-1:0] wr_data
);

    source_state_e          state;
    pattern_e               mode;
    logic [DATA_WIDTH-1:0]  word;
    logic [LEN_WIDTH-1:0]   remaining;
    logic                   last_word;

    // Next word of the sequence for the latched opcode
    function automatic logic [DATA_WIDTH-1:0] next_word(
        input pattern_e              op,
        input logic [DATA_WIDTH-1:0] w
    );
        logic [DATA_WIDTH-1:0] step;
        case (op)
            PAT_RAMP: step = w + 1'b1;
            PAT_LFSR: step = (w >> 1) ^ (w[0] ? LFSR_POLY : '0);
            default:  step = w;
        endcase
        return step;
    endfunction

    assign busy      = (state == SRC_EMIT);
    assign last_word = (remaining == LEN_WIDTH'(1));
    assign wr_data   = word;

    // A zero length command spends one cycle in EMIT without writing
    assign wr_en = busy && !full && (remaining != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= SRC_IDLE;
            mode      <= PAT_CONST;
            remaining <= '0;
        end else begin
            case (state)
                SRC_IDLE: begin
                    if (start) begin
                        state     <= SRC_EMIT;
                        mode      <= opcode;
                        remaining <= length;
                    end
                end
                SRC_EMIT: begin
                    if (remaining == '0) begin
                        state <= SRC_IDLE;
                    end else if (wr_en) begin
                        remaining <= remaining - 1'b1;
                        if (last_word) begin
                            state <= SRC_IDLE;
                        end
                    end
                end
                default: state <= SRC_IDLE;
            endcase
        end
    end

    // Current word only moves on an accepted write, so it holds under back-pressure
    always_ff @(posedge clk) begin
        if (state == SRC_IDLE && start) begin
            word <= seed;
        end else if (wr_en) begin
            word <= next_word(mode, word);
        end
    end

endmodule

// File: design/stream_pkg.sv
package stream_pkg;

    // Width of the length field of a command
    localparam int LEN_WIDTH = 8;

    // Galois feedback mask, right shifting form of x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_POLY = 32'h8020_0003;

    // Pattern opcodes
    typedef enum logic [1:0] {
        PAT_CONST = 2'd0,
        PAT_RAMP  = 2'd1,
        PAT_LFSR  = 2'd2
    } pattern_e;

    // Source control states
    typedef enum logic {
        SRC_IDLE = 1'b0,
        SRC_EMIT = 1'b1
    } source_state_e;

endpackage

// File: design/fifo_pkg.sv
package fifo_pkg;

    // Stored word width
    localparam int DATA_WIDTH = 32;

    // Memory geometry
    localparam int ADDR_WIDTH = 4;
    localparam int DEPTH      = 1 << ADDR_WIDTH;

    // Stages in the write commit path and in the read data path
    localparam int PIPE_STAGES = 2;

    // almost_full rises when free entries drop to this many or fewer
    localparam int ALMOST_FULL_MARGIN = 4;

    // almost_empty stays high while this many or fewer words are stored
    localparam int ALMOST_EMPTY_MARGIN = 4;

    // One extra bit so a completely full memory can be told from empty
    localparam int COUNT_WIDTH = ADDR_WIDTH + 1;

endpackage
